// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - .

sources:
  - ic_geom_pkg.sv
  - ic_ctrl_pkg.sv
  - ic_if.sv
  - icache_ctrl.sv
  - icache_tag_array.sv
  - icache_data_array.sv
  - icache_refill.sv
  - icache_top.sv
  - target: test
    files:
      - icache_asserts.sv
      - tb_icache.sv

// ==== build.f ====
+incdir+.
ic_geom_pkg.sv
ic_ctrl_pkg.sv
ic_if.sv
icache_ctrl.sv
icache_tag_array.sv
icache_data_array.sv
icache_refill.sv
icache_top.sv
icache_asserts.sv
tb_icache.sv

// ==== ic_ctrl_pkg.sv ====
// Instruction cache control types
// Front-end FSM states and the outcome of a line refill

package ic_ctrl_pkg;

  // Front-end FSM
  typedef enum logic [2:0] {
    IDLE,    // Waiting for fetch or flush
    LOOKUP,  // Hit result valid this cycle
    REFILL,  // Line burst in progress
    WRITE,   // Victim way written
    FLUSH    // Walking all sets
  } ic_state_e;

  // Refill outcome
  typedef enum logic {
    OK,      // All words clean
    BUS_ERR  // At least one ack with error
  } ic_fill_status_e;

endpackage

// ==== ic_geom_pkg.sv ====
// Instruction cache geometry types
// Address fields, words, lines and way masks, all derived from the
// settings macros

`include "ic_settings.svh"

package ic_geom_pkg;

  // Derived field widths
  localparam int unsigned IC_BYTE_BITS = $clog2(`IC_XLEN / 8);
  localparam int unsigned IC_OFFS_BITS = $clog2(`IC_BURST_LEN);
  localparam int unsigned IC_IDX_BITS  = $clog2(`IC_SETS);
  localparam int unsigned IC_TAG_BITS  = `IC_XLEN - IC_IDX_BITS - IC_OFFS_BITS - IC_BYTE_BITS;
  localparam int unsigned IC_LINE_BITS = `IC_XLEN * `IC_BURST_LEN;
  localparam int unsigned IC_WAY_BITS  = (`IC_WAYS > 1) ? $clog2(`IC_WAYS) : 1;

  typedef logic [`IC_XLEN-1:0]     ic_addr_t;  // Byte address
  typedef logic [`IC_XLEN-1:0]     ic_word_t;  // Instruction word
  typedef logic [IC_TAG_BITS-1:0]  ic_tag_t;   // Address bits 31:8
  typedef logic [IC_IDX_BITS-1:0]  ic_idx_t;   // Address bits 7:4
  typedef logic [IC_OFFS_BITS-1:0] ic_offs_t;  // Address bits 3:2
  typedef logic [IC_LINE_BITS-1:0] ic_line_t;  // Word 0 in low bits
  typedef logic [`IC_WAYS-1:0]     ic_way_t;   // One-hot way mask

endpackage

// ==== ic_if.sv ====
// Instruction cache internal interfaces
// ic_array_if carries lookup, write and invalidate from the controller
// to tag and data storage, plus hit and word back
// ic_refill_if carries the line request to the burst engine and the
// assembled line to the controller and data array

`timescale 1ns/1ns

interface ic_array_if;
  ic_geom_pkg::ic_idx_t  idx;      // Lookup and write set
  ic_geom_pkg::ic_offs_t offs;     // Word within line
  ic_geom_pkg::ic_tag_t  tag;      // Compare and write tag
  logic                  we;       // Write refill line
  ic_geom_pkg::ic_way_t  we_way;   // Victim way, one-hot
  logic                  inv;      // Invalidate one set
  ic_geom_pkg::ic_idx_t  inv_idx;
  logic                  hit;      // Registered, cycle after lookup
  ic_geom_pkg::ic_way_t  hit_way;
  ic_geom_pkg::ic_word_t word;     // Parcel of the hit way

  modport ctrl (
    output idx, offs, tag, we, we_way, inv, inv_idx,
    input  hit, hit_way, word
  );

  modport array (
    input  idx, offs, tag, we, we_way, inv, inv_idx,
    output hit, hit_way, word
  );
endinterface

interface ic_refill_if;
  logic                         start;   // Single-cycle request
  ic_geom_pkg::ic_addr_t        addr;    // Line aligned
  logic                         done;    // Single cycle after last word
  ic_ctrl_pkg::ic_fill_status_e status;
  ic_geom_pkg::ic_line_t        line;    // Stable from done to next start

  modport ctrl   (output start, addr, input done, status);
  modport engine (input start, addr, output done, status, line);
  modport fill   (input line);
endinterface

// ==== ic_settings.svh ====
// Instruction cache settings
// Word width, geometry and victim generator width shared by the
// geometry package and the RTL blocks
`ifndef IC_SETTINGS_SVH
`define IC_SETTINGS_SVH

// Word and byte address width
`define IC_XLEN      32
// Sets per way
`define IC_SETS      16
// Associativity
`define IC_WAYS      2
// Words per line, one burst
`define IC_BURST_LEN 4
// Width of the XNOR random generator
`define IC_RND_BITS  7

`endif

// ==== icache_asserts.sv ====
// Instruction cache protocol checks
// Bound to the top level, watches the bus burst, the CPU strobes
// and the two-cycle hit latency

`timescale 1ns/1ns

module icache_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic biu_stb_o,
  input logic biu_ack_i,
  input logic parcel_valid_o,
  input logic flush_done_o
);

  int pending_q;     // Words still owed by the bus
  int fail_cnt = 0;  // Failed properties so far

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) pending_q <= 0;
    else pending_q <= pending_q + (biu_stb_o ? 4 : 0) - (biu_ack_i ? 1 : 0);
  end

  // No new burst while a line is still arriving
  assert property (@(posedge clk_i) disable iff (!rst_ni) biu_stb_o |-> pending_q == 0)
    else begin
      fail_cnt++;
      $error("bus strobe during refill");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(parcel_valid_o && flush_done_o))
    else begin
      fail_cnt++;
      $error("parcel and flush done together");
    end

  // Two cycles after a request either the hit parcel or a burst
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   req_i |-> ##2 (parcel_valid_o != biu_stb_o))
    else begin
      fail_cnt++;
      $error("hit latency not two cycles");
    end

endmodule

// ==== icache_ctrl.sv ====
// Instruction cache controller
// Holds the fetch address, runs the front-end FSM, picks the victim
// way from a 7-bit XNOR random generator and walks the sets on flush

`timescale 1ns/1ns
`include "ic_settings.svh"

module icache_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  ic_geom_pkg::ic_addr_t adr_i,
  input  logic                  flush_i,
  output ic_geom_pkg::ic_word_t parcel_o,
  output logic                  parcel_valid_o,
  output logic                  parcel_error_o,
  output logic                  flush_done_o,
  ic_array_if.ctrl              arr,
  ic_refill_if.ctrl             fill
);

  localparam int unsigned BYTE_BITS = ic_geom_pkg::IC_BYTE_BITS;
  localparam int unsigned LINE_LSB  = BYTE_BITS + ic_geom_pkg::IC_OFFS_BITS;
  localparam ic_geom_pkg::ic_idx_t LAST_IDX = ic_geom_pkg::ic_idx_t'(`IC_SETS - 1);

  ic_ctrl_pkg::ic_state_e  state_q, state_d;
  ic_geom_pkg::ic_addr_t   adr_q;        // Held fetch address
  ic_geom_pkg::ic_addr_t   look_adr;     // Address into the arrays
  ic_geom_pkg::ic_idx_t    flush_idx_q;  // Flush walker
  logic [`IC_RND_BITS-1:0] rnd_q;        // Victim generator
  logic                    fill_err;     // Refill ended with bus error

  // ----------------------------------------
  // Array and refill drive
  // ----------------------------------------
  // In IDLE the new request goes straight into the arrays
  assign look_adr = (state_q == ic_ctrl_pkg::IDLE) ? adr_i : adr_q;

  assign arr.offs    = look_adr[BYTE_BITS +: ic_geom_pkg::IC_OFFS_BITS];
  assign arr.idx     = look_adr[LINE_LSB +: ic_geom_pkg::IC_IDX_BITS];
  assign arr.tag     = look_adr[`IC_XLEN-1 -: ic_geom_pkg::IC_TAG_BITS];
  assign arr.we      = (state_q == ic_ctrl_pkg::WRITE);
  assign arr.we_way  = ic_geom_pkg::ic_way_t'(1) << rnd_q[ic_geom_pkg::IC_WAY_BITS-1:0];
  assign arr.inv     = (state_q == ic_ctrl_pkg::FLUSH);
  assign arr.inv_idx = flush_idx_q;

  assign fill.start = (state_q == ic_ctrl_pkg::LOOKUP) && !arr.hit;  // Miss
  assign fill.addr  = {adr_q[`IC_XLEN-1:LINE_LSB], {LINE_LSB{1'b0}}};

  assign fill_err = (state_q == ic_ctrl_pkg::REFILL) && fill.done &&
                    (fill.status == ic_ctrl_pkg::BUS_ERR);

  // Random generator, frozen while a line is being replaced
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_q <= '0;
    end else if (state_q != ic_ctrl_pkg::REFILL && state_q != ic_ctrl_pkg::WRITE) begin
      rnd_q <= {rnd_q[`IC_RND_BITS-2:0], rnd_q[`IC_RND_BITS-1] ~^ rnd_q[`IC_RND_BITS-2]};
    end
  end

  // ----------------------------------------
  // Front-end FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ic_ctrl_pkg::IDLE: begin
        if (flush_i) begin
          state_d = ic_ctrl_pkg::FLUSH;
        end else if (req_i) begin
          state_d = ic_ctrl_pkg::LOOKUP;
        end
      end
      ic_ctrl_pkg::LOOKUP: state_d = arr.hit ? ic_ctrl_pkg::IDLE : ic_ctrl_pkg::REFILL;
      ic_ctrl_pkg::REFILL: begin
        if (fill.done) begin
          state_d = fill_err ? ic_ctrl_pkg::IDLE : ic_ctrl_pkg::WRITE;
        end
      end
      ic_ctrl_pkg::WRITE:  state_d = ic_ctrl_pkg::LOOKUP;  // Re-lookup hits
      ic_ctrl_pkg::FLUSH: begin
        if (flush_idx_q == LAST_IDX) state_d = ic_ctrl_pkg::IDLE;
      end
      default: state_d = ic_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= ic_ctrl_pkg::IDLE;
      flush_idx_q    <= '0;
      parcel_valid_o <= 1'b0;
      parcel_error_o <= 1'b0;
      flush_done_o   <= 1'b0;
    end else begin
      state_q        <= state_d;
      parcel_valid_o <= ((state_q == ic_ctrl_pkg::LOOKUP) && arr.hit) || fill_err;
      parcel_error_o <= fill_err;
      flush_done_o   <= (state_q == ic_ctrl_pkg::FLUSH) && (flush_idx_q == LAST_IDX);
      // Walker restarts from set 0 outside FLUSH
      flush_idx_q    <= (state_q == ic_ctrl_pkg::FLUSH) ? flush_idx_q + 1'b1 : '0;
    end
  end

  // Address and parcel payload
  always_ff @(posedge clk_i) begin
    if (state_q == ic_ctrl_pkg::IDLE && req_i) adr_q <= adr_i;
    if (state_q == ic_ctrl_pkg::LOOKUP) begin
      parcel_o <= arr.word;
    end else if (fill_err) begin
      parcel_o <= '0;  // No data on bus error
    end
  end

endmodule

// ==== icache_data_array.sv ====
// Instruction cache data array
// Line storage per set and way. Each way reads its word at the lookup
// offset into a register; the registered hit way picks the parcel.
// A refill line is written into the victim way and forwarded

`timescale 1ns/1ns
`include "ic_settings.svh"

module icache_data_array (
  input  logic      clk_i,
  ic_array_if.array arr,
  ic_refill_if.fill fill
);

  ic_geom_pkg::ic_line_t line_mem [`IC_WAYS][`IC_SETS];
  ic_geom_pkg::ic_word_t rd_q     [`IC_WAYS];  // Word per way at offset

  // Line write and synchronous word read
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `IC_WAYS; w++) begin
      if (arr.we && arr.we_way[w]) begin
        line_mem[w][arr.idx] <= fill.line;
        rd_q[w] <= fill.line[arr.offs*`IC_XLEN +: `IC_XLEN];  // New line forwarded
      end else begin
        rd_q[w] <= line_mem[w][arr.idx][arr.offs*`IC_XLEN +: `IC_XLEN];
      end
    end
  end

  // One-hot mux by hit way, zero on miss
  always_comb begin
    arr.word = '0;
    for (int w = 0; w < `IC_WAYS; w++) begin
      if (arr.hit_way[w]) arr.word = arr.word | rd_q[w];
    end
  end

endmodule

// ==== icache_refill.sv ====
// Instruction cache refill engine
// Pulses the bus strobe with the line address, shifts each acked word
// into the line, collects bus errors and signals done with the status
// one cycle after the final word

`timescale 1ns/1ns
`include "ic_settings.svh"

module icache_refill (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  ic_refill_if.engine           fill,
  output logic                  biu_stb_o,
  output ic_geom_pkg::ic_addr_t biu_adri_o,
  input  logic                  biu_ack_i,
  input  ic_geom_pkg::ic_word_t biu_q_i,
  input  logic                  biu_err_i
);

  localparam int unsigned CNT_BITS = $clog2(`IC_BURST_LEN);
  localparam int unsigned LINE_MSB = ic_geom_pkg::IC_LINE_BITS - 1;

  logic                busy_q;    // Burst in progress
  logic [CNT_BITS-1:0] cnt_q;     // Words received
  logic                err_q;     // Error seen so far
  logic                word_ack;
  logic                last_ack;

  assign word_ack = busy_q && biu_ack_i;
  assign last_ack = word_ack && (cnt_q == CNT_BITS'(`IC_BURST_LEN - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      cnt_q       <= '0;
      err_q       <= 1'b0;
      biu_stb_o   <= 1'b0;
      fill.done   <= 1'b0;
      fill.status <= ic_ctrl_pkg::OK;
    end else begin
      biu_stb_o <= fill.start;  // Single-cycle request
      fill.done <= last_ack;
      if (fill.start) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
        err_q  <= 1'b0;
      end else if (word_ack) begin
        cnt_q <= cnt_q + 1'b1;
        err_q <= err_q | biu_err_i;
        if (last_ack) busy_q <= 1'b0;
      end
      if (last_ack) begin
        fill.status <= (err_q || biu_err_i) ? ic_ctrl_pkg::BUS_ERR : ic_ctrl_pkg::OK;
      end
    end
  end

  // Address and line payload
  always_ff @(posedge clk_i) begin
    if (fill.start) biu_adri_o <= fill.addr;
    // Words arrive ascending, shift down so word 0 ends in the low bits
    if (word_ack) fill.line <= {biu_q_i, fill.line[LINE_MSB:`IC_XLEN]};
  end

endmodule

// ==== icache_stim.txt ====
# F address expected_parcel miss(0/1, 2 = don't care) error
# X = flush all sets
F 00001000 a5a51000 1 0
F 00001008 a5a51008 0 0
F 00002000 a5a52000 1 0
F 0000200c a5a5200c 0 0
F 00001004 a5a51004 2 0
F 00002004 a5a52004 2 0
F 00003000 a5a53000 1 0
F 00003008 a5a53008 0 0
F 00000010 a5a50010 1 0
F 0000001c a5a5001c 0 0
F 80000040 00000000 1 1
F 80000040 00000000 1 1
X
F 00003004 a5a53004 1 0
F 00003000 a5a53000 0 0
F 00000014 a5a50014 1 0
F 00000018 a5a50018 0 0

// ==== icache_tag_array.sv ====
// Instruction cache tag array
// Tag and valid bit per set and way, compared against the lookup tag
// with the result registered one cycle later. Invalidate clears one
// set in every way; a refill write counts as a match in its own way

`timescale 1ns/1ns
`include "ic_settings.svh"

module icache_tag_array (
  input  logic      clk_i,
  input  logic      rst_ni,
  ic_array_if.array arr
);

  ic_geom_pkg::ic_tag_t tag_mem [`IC_WAYS][`IC_SETS];  // No reset, guarded by valid
  logic [`IC_SETS-1:0]  valid_q [`IC_WAYS];
  ic_geom_pkg::ic_way_t match;                         // Per-way compare

  // Compare, way under write forwards its new tag
  always_comb begin
    for (int w = 0; w < `IC_WAYS; w++) begin
      match[w] = (arr.we && arr.we_way[w]) ||
                 (valid_q[w][arr.idx] && (tag_mem[w][arr.idx] == arr.tag));
    end
  end

  // Tag write on refill
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `IC_WAYS; w++) begin
      if (arr.we && arr.we_way[w]) tag_mem[w][arr.idx] <= arr.tag;
    end
  end

  // Valid bits, invalidate wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `IC_WAYS; w++) valid_q[w] <= '0;
    end else begin
      for (int w = 0; w < `IC_WAYS; w++) begin
        if (arr.inv) begin
          valid_q[w][arr.inv_idx] <= 1'b0;
        end else if (arr.we && arr.we_way[w]) begin
          valid_q[w][arr.idx] <= 1'b1;
        end
      end
    end
  end

  // Registered hit, one cycle after lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arr.hit     <= 1'b0;
      arr.hit_way <= '0;
    end else begin
      arr.hit     <= |match;
      arr.hit_way <= match;
    end
  end

endmodule

// ==== icache_top.sv ====
// Instruction cache top level
// Two-way set-associative fetch cache with plain CPU and bus ports.
// Wires the controller, tag and data arrays and refill engine

`timescale 1ns/1ns

module icache_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // CPU side
  input  logic                  req_i,
  input  ic_geom_pkg::ic_addr_t adr_i,
  output ic_geom_pkg::ic_word_t parcel_o,
  output logic                  parcel_valid_o,
  output logic                  parcel_error_o,
  input  logic                  flush_i,
  output logic                  flush_done_o,
  // Bus side
  output logic                  biu_stb_o,
  output ic_geom_pkg::ic_addr_t biu_adri_o,
  input  logic                  biu_ack_i,
  input  ic_geom_pkg::ic_word_t biu_q_i,
  input  logic                  biu_err_i
);

  ic_array_if  arr_if ();
  ic_refill_if fill_if ();

  // ----------------------------------------
  // Front end
  // ----------------------------------------
  icache_ctrl u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .adr_i          ( adr_i          ),
    .flush_i        ( flush_i        ),
    .parcel_o       ( parcel_o       ),
    .parcel_valid_o ( parcel_valid_o ),
    .parcel_error_o ( parcel_error_o ),
    .flush_done_o   ( flush_done_o   ),
    .arr            ( arr_if.ctrl    ),
    .fill           ( fill_if.ctrl   )
  );

  // ----------------------------------------
  // Storage and refill
  // ----------------------------------------
  icache_tag_array u_tag (
    .clk_i  ( clk_i        ),
    .rst_ni ( rst_ni       ),
    .arr    ( arr_if.array )
  );

  icache_data_array u_data (
    .clk_i ( clk_i        ),
    .arr   ( arr_if.array ),
    .fill  ( fill_if.fill )
  );

  icache_refill u_refill (
    .clk_i      ( clk_i          ),
    .rst_ni     ( rst_ni         ),
    .fill       ( fill_if.engine ),
    .biu_stb_o  ( biu_stb_o      ),
    .biu_adri_o ( biu_adri_o     ),
    .biu_ack_i  ( biu_ack_i      ),
    .biu_q_i    ( biu_q_i        ),
    .biu_err_i  ( biu_err_i      )
  );

endmodule

// ==== tb_icache.sv ====
// Instruction cache testbench
// Reads fetch and flush commands from the stim file, drives the CPU
// side, models the bus with random ack gaps and checks every parcel

`timescale 1ns/1ns
`include "ic_settings.svh"

module tb_icache;

  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic clk_i;
  logic rst_ni;
  logic req_i;
  logic flush_i;
  logic biu_ack_i;
  logic biu_err_i;
  logic parcel_valid_o;
  logic parcel_error_o;
  logic flush_done_o;
  logic biu_stb_o;
  ic_geom_pkg::ic_addr_t adr_i;
  ic_geom_pkg::ic_addr_t biu_adri_o;
  ic_geom_pkg::ic_word_t biu_q_i;
  ic_geom_pkg::ic_word_t parcel_o;

  int          miss_cnt;     // Bursts seen so far
  logic [19:0] lfsr_q;       // Ack gap source
  logic        bus_busy;
  ic_geom_pkg::ic_addr_t bus_adr;
  ic_geom_pkg::ic_addr_t fetch_adr;  // Address of the fetch in flight
  int          bus_cnt;
  int          bus_gap;

  icache_top dut (.*);

  bind icache_top icache_asserts u_asserts (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req_i          ),
    .biu_stb_o      ( biu_stb_o      ),
    .biu_ack_i      ( biu_ack_i      ),
    .parcel_valid_o ( parcel_valid_o ),
    .flush_done_o   ( flush_done_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Fibonacci LFSR with taps at x^20 and x^17
  function automatic logic [19:0] lfsr_next(input logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  task automatic draw_gap(output int g);
    g = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_q = lfsr_next(lfsr_q);  // One step per bit
      g = (g << 1) | lfsr_q[0];
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    end
  endtask

  // Protocol properties of the bound checker
  always @(posedge clk_i) begin
    if (dut.u_asserts.fail_cnt != 0) stop_run("A protocol assertion failed");
  end

  // ----------------------------------------
  // Bus memory model
  // ----------------------------------------
  always @(posedge clk_i) begin
    biu_ack_i <= 1'b0;
    biu_err_i <= 1'b0;
    if (!rst_ni) begin
      bus_busy = 1'b0;
    end else if (!bus_busy) begin
      if (biu_stb_o) begin  // New burst
        // Line of the fetch, 16 bytes per line
        check("biu_adri_o", biu_adri_o,
              fetch_adr & ~32'(`IC_BURST_LEN * (`IC_XLEN / 8) - 1));
        bus_busy = 1'b1;
        bus_adr  = biu_adri_o;
        bus_cnt  = 0;
        draw_gap(bus_gap);
        miss_cnt <= miss_cnt + 1;
      end
    end else if (bus_gap > 0) begin
      bus_gap--;
    end else begin
      biu_ack_i <= 1'b1;
      biu_q_i   <= bus_adr ^ 32'hA5A50000;  // Memory rule
      biu_err_i <= bus_adr[31];
      bus_adr   = bus_adr + 4;
      bus_cnt++;
      if (bus_cnt == `IC_BURST_LEN) bus_busy = 1'b0;
      else draw_gap(bus_gap);
    end
  end

  // ----------------------------------------
  // CPU side commands
  // ----------------------------------------
  task automatic fetch(input logic [31:0] a, input logic [31:0] exp_p,
                       input int exp_m, input int exp_e);
    int n;
    int start_miss;
    start_miss = miss_cnt;
    fetch_adr  = a;
    @(posedge clk_i);
    req_i <= 1'b1;
    adr_i <= a;
    @(posedge clk_i);
    req_i <= 1'b0;
    n = 0;
    while (1) begin
      @(posedge clk_i);
      if (parcel_valid_o) break;
      n++;
      if (n > TIMEOUT) stop_run($sformatf("Timeout waiting for a parcel at %h", a));
    end
    check("parcel_o", parcel_o, exp_p);
    check("parcel_error_o", 32'(parcel_error_o), 32'(exp_e));
    if (exp_m != 2) check("miss", 32'(miss_cnt != start_miss), 32'(exp_m));  // 2 is don't care
  endtask

  task automatic flush();
    int n;
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    n = 0;
    while (1) begin
      @(posedge clk_i);
      if (flush_done_o) break;
      n++;
      if (n > TIMEOUT) stop_run("Timeout waiting for the flush to finish");
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int fd;
    int code;
    logic [8*8-1:0]   cmd;
    logic [8*128-1:0] junk;
    logic [31:0] a;
    logic [31:0] p;
    int m;
    int e;
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    adr_i     = '0;
    flush_i   = 1'b0;
    biu_ack_i = 1'b0;
    biu_q_i   = '0;
    biu_err_i = 1'b0;
    miss_cnt  = 0;
    fetch_adr = '0;
    lfsr_q    = 20'd83213;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    fd = $fopen("icache_stim.txt", "r");
    if (fd == 0) stop_run("Cannot open the stimulus file");
    while (1) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) break;
      if (cmd == "#") begin
        code = $fgets(junk, fd);  // Skip comment line
      end else if (cmd == "F") begin
        code = $fscanf(fd, "%h %h %d %d", a, p, m, e);
        fetch(a, p, m, e);
      end else if (cmd == "X") begin
        flush();
      end else begin
        stop_run("Unknown command in the stimulus file");
      end
    end
    $fclose(fd);
    if (dut.u_asserts.fail_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_run("A protocol assertion failed");
    end
  end

endmodule
